// ==== Bender.yml ====
package:
  name: instr_prefetch

sources:
  # Packages first, then RTL bottom-up
  - files:
      - src/fetch_cfg_pkg.sv
      - src/mem_bus_pkg.sv
      - src/prefetch_ctrl.sv
      - src/fetch_fifo.sv
      - src/mem_arbiter.sv
      - src/instr_ram.sv
      - src/prefetch_top.sv
  # Checker and testbench
  - target: simulation
    files:
      - sim/prefetch_chk.sv
      - sim/tb_prefetch.sv

// ==== sim/prefetch_chk.sv ====
// Bound checker for prefetch_top, asserting fetch data, flush, occupancy and handshake rules
module prefetch_chk
  import fetch_cfg_pkg::*;
#(
  parameter int DEPTH = 4,
  localparam int CNT_W = $clog2(DEPTH + 1)
) (
  input logic             clk,
  input logic             rst_n,
  // Fetch stage side
  input logic             branch_i,
  input logic [31:0]      branch_addr_i,
  input logic             fetch_ready_i,
  input logic             fetch_valid_i,
  input logic [31:0]      fetch_instr_i,
  input logic [31:0]      fetch_addr_i,
  input logic             busy_i,
  // External port
  input logic             ext_req_i,
  input logic             ext_ack_i,
  // Internal fetch path
  input logic             trans_valid_i,
  input logic             trans_ready_i,
  input logic             resp_valid_i,
  input logic [CNT_W-1:0] fifo_cnt_i,
  input logic             mem_en_i
);

  timeunit 1ns;
  timeprecision 100ps;

  // Program image rule, word address XOR pattern
  localparam logic [31:0] PROG_PATTERN = 32'hA5A5_0000;

  logic [31:0]    exp_addr_q;
  logic [CNT_W:0] outst_q;
  logic           consume;
  logic           accept;
  int             err_cnt = 0;

  // Words taken in a branch cycle belong to the old path
  assign consume = fetch_valid_i && fetch_ready_i && !branch_i;
  assign accept  = trans_valid_i && trans_ready_i;

  ////////////////////////////////////////
  // Reference models
  ////////////////////////////////////////

  // Next address the fetch stage should see
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      exp_addr_q <= BOOT_ADDR;
    end else if (branch_i) begin
      exp_addr_q <= {branch_addr_i[31:2], 2'b00};
    end else if (consume) begin
      exp_addr_q <= exp_addr_q + 32'd4;
    end
  end

  // Fetches accepted by the arbiter and not yet answered
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      outst_q <= '0;
    end else if (accept && !resp_valid_i) begin
      outst_q <= outst_q + 1'b1;
    end else if (!accept && resp_valid_i) begin
      outst_q <= outst_q - 1'b1;
    end
  end

  ////////////////////////////////////////
  // Assertions
  ////////////////////////////////////////

  // Everything quiet on the first edge out of reset
  reset_quiet_a: assert property (@(posedge clk) $rose(rst_n) |->
      !trans_valid_i && !fetch_valid_i && !busy_i && !ext_ack_i && !mem_en_i)
    else begin
      err_cnt++;
      $error("[FAIL] %0t ns: outputs active right after reset", $time);
    end

  // Consumed word sits at the expected address and carries the program word
  fetch_data_a: assert property (@(posedge clk) disable iff (!rst_n) consume |->
      (fetch_addr_i == exp_addr_q) && (fetch_instr_i == (fetch_addr_i ^ PROG_PATTERN)))
    else begin
      err_cnt++;
      $error("[FAIL] %0t ns: consumed addr %08h data %08h, expected addr %08h",
             $time, $sampled(fetch_addr_i), $sampled(fetch_instr_i), $sampled(exp_addr_q));
    end

  // FIFO empty right after a branch
  flush_a: assert property (@(posedge clk) disable iff (!rst_n) branch_i |=> !fetch_valid_i)
    else begin
      err_cnt++;
      $error("[FAIL] %0t ns: FIFO not empty after branch", $time);
    end

  // Never more words buffered or in flight than DEPTH
  occupancy_a: assert property (@(posedge clk) disable iff (!rst_n)
      (fifo_cnt_i + outst_q) <= DEPTH)
    else begin
      err_cnt++;
      $error("[FAIL] %0t ns: occupancy %0d above depth", $time,
             $sampled(fifo_cnt_i) + $sampled(outst_q));
    end

  // One-cycle response to every accepted fetch, and no stray ones
  resp_timing_a: assert property (@(posedge clk) disable iff (!rst_n) accept |=> resp_valid_i)
    else begin
      err_cnt++;
      $error("[FAIL] %0t ns: fetch response missing", $time);
    end

  resp_origin_a: assert property (@(posedge clk) disable iff (!rst_n)
      resp_valid_i |-> $past(accept))
    else begin
      err_cnt++;
      $error("[FAIL] %0t ns: fetch response without request", $time);
    end

  // Four-phase rules on the external port
  // Req is judged on the edge that raised ack, the host may drop it right after
  ack_rise_a: assert property (@(posedge clk) disable iff (!rst_n)
      $rose(ext_ack_i) |-> $past(ext_req_i))
    else begin
      err_cnt++;
      $error("[FAIL] %0t ns: ext ack rose without req", $time);
    end

  ack_fall_a: assert property (@(posedge clk) disable iff (!rst_n)
      $fell(ext_ack_i) |-> !$past(ext_req_i))
    else begin
      err_cnt++;
      $error("[FAIL] %0t ns: ext ack fell while req high", $time);
    end

endmodule

bind prefetch_top prefetch_chk #(.DEPTH(DEPTH)) u_chk (
  .clk, .rst_n, .branch_i, .branch_addr_i, .fetch_ready_i, .ext_req_i,
  .fetch_valid_i (fetch_valid_o),
  .fetch_instr_i (fetch_instr_o),
  .fetch_addr_i  (fetch_addr_o),
  .busy_i        (busy_o),
  .ext_ack_i     (ext_ack_o),
  .trans_valid_i (trans_valid),
  .trans_ready_i (trans_ready),
  .resp_valid_i  (resp_valid),
  .fifo_cnt_i    (fifo_cnt),
  .mem_en_i      (mem_en)
);

// ==== sim/tb_prefetch.sv ====
// Testbench for the prefetch subsystem, loads the program over the external port then drives fetch traffic
module tb_prefetch
  import mem_bus_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int          DEPTH        = 4;
  localparam int          MEM_WORDS    = 256;
  localparam logic [31:0] PROG_PATTERN = 32'hA5A5_0000;
  // Cycles allowed for one ack edge
  localparam int          ACK_LIMIT    = 50;

  logic        clk;
  logic        rst_n;
  logic        fetch_req;
  logic        branch;
  logic [31:0] branch_addr;
  logic        fetch_ready;
  logic        fetch_valid;
  logic [31:0] fetch_instr;
  logic [31:0] fetch_addr;
  logic        busy;
  logic        ext_req;
  mem_op_e     ext_op;
  logic [31:0] ext_addr;
  logic [31:0] ext_wdata;
  logic        ext_ack;
  logic [31:0] ext_rdata;

  logic [31:0] lcg_state = 32'h359e;
  int          tb_errs;
  int          errs_seen;
  int          tests_run;
  int          tests_failed;

  prefetch_top #(.DEPTH(DEPTH), .MEM_WORDS(MEM_WORDS)) UUT (
    .clk, .rst_n,
    .fetch_req_i   (fetch_req),
    .branch_i      (branch),
    .branch_addr_i (branch_addr),
    .fetch_ready_i (fetch_ready),
    .fetch_valid_o (fetch_valid),
    .fetch_instr_o (fetch_instr),
    .fetch_addr_o  (fetch_addr),
    .busy_o        (busy),
    .ext_req_i     (ext_req),
    .ext_op_i      (ext_op),
    .ext_addr_i    (ext_addr),
    .ext_wdata_i   (ext_wdata),
    .ext_ack_o     (ext_ack),
    .ext_rdata_o   (ext_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    // Low bits of an LCG repeat quickly
    return lcg_state >> 8;
  endfunction

  function automatic int total_errors();
    return tb_errs + UUT.u_chk.err_cnt;
  endfunction

  task automatic stop_on_timeout(input string what);
    $display("Timeout at %0t ns while waiting for %s", $time, what);
    $display("Simulation finished: FAIL");
    $finish;
  endtask

  task automatic finish_test(input string name);
    int total;
    int delta;
    // Give assertions on the last edges time to fire
    repeat (2) @(negedge clk);
    total     = total_errors();
    delta     = total - errs_seen;
    errs_seen = total;
    tests_run++;
    if (delta == 0) begin
      $display("Test %-12s passed at %0t ns", name, $time);
    end else begin
      tests_failed++;
      $display("Test %-12s failed with %0d errors", name, delta);
    end
  endtask

  // One four-phase access on the external port
  task automatic ext_access(input mem_op_e op, input logic [31:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata);
    int waited;
    @(negedge clk);
    ext_op    = op;
    ext_addr  = addr;
    ext_wdata = wdata;
    ext_req   = 1'b1;
    waited    = 0;
    while (!ext_ack) begin
      @(negedge clk);
      waited++;
      if (waited > ACK_LIMIT) begin
        stop_on_timeout("ext_ack_o to rise");
      end
    end
    rdata   = ext_rdata;
    ext_req = 1'b0;
    waited  = 0;
    while (ext_ack) begin
      @(negedge clk);
      waited++;
      if (waited > ACK_LIMIT) begin
        stop_on_timeout("ext_ack_o to fall");
      end
    end
  endtask

  task automatic check_ext_read(input logic [31:0] addr);
    logic [31:0] rdata;
    logic [31:0] expected;
    expected = addr ^ PROG_PATTERN;
    ext_access(MEM_READ, addr, 32'h0, rdata);
    if (rdata !== expected) begin
      tb_errs++;
      $display("[FAIL] %0t ns: ext read at 0x%08h returned 0x%08h, expected 0x%08h",
               $time, addr, rdata, expected);
    end
  endtask

  task automatic load_program();
    logic [31:0] addr;
    logic [31:0] echo;
    for (int i = 0; i < MEM_WORDS; i++) begin
      addr = 32'(i * 4);
      ext_access(MEM_WRITE, addr, addr ^ PROG_PATTERN, echo);
    end
  endtask

  // Take n words, fetch_ready high with probability pct percent
  task automatic consume_words(input int n, input int pct);
    int   got;
    int   waited;
    logic take;
    got    = 0;
    waited = 0;
    while (got < n) begin
      @(negedge clk);
      take        = int'(next_rand() % 100) < pct;
      fetch_ready = take;
      if (take && fetch_valid) begin
        got++;
      end
      waited++;
      if (waited > n * 40 + 100) begin
        stop_on_timeout("fetched words to arrive");
      end
    end
  endtask

  task automatic take_branch(input logic [31:0] target);
    @(negedge clk);
    fetch_ready = 1'b0;
    branch      = 1'b1;
    branch_addr = target;
    @(negedge clk);
    branch      = 1'b0;
  endtask

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////

  initial begin
    int total;
    rst_n        = 1'b0;
    fetch_req    = 1'b0;
    branch       = 1'b0;
    branch_addr  = '0;
    fetch_ready  = 1'b0;
    ext_req      = 1'b0;
    ext_op       = MEM_READ;
    ext_addr     = '0;
    ext_wdata    = '0;
    tb_errs      = 0;
    errs_seen    = 0;
    tests_run    = 0;
    tests_failed = 0;

    repeat (2) @(negedge clk);
    rst_n = 1'b1;
    repeat (3) @(negedge clk);
    finish_test("reset");

    // Program image first, then spot reads
    load_program();
    for (int i = 0; i < 16; i++) begin
      check_ext_read((next_rand() % MEM_WORDS) * 4);
    end
    finish_test("ext_port");

    @(negedge clk);
    fetch_req = 1'b1;
    consume_words(24, 100);
    finish_test("sequential");

    // Short runs keep some fetches in flight at each branch
    for (int i = 0; i < 12; i++) begin
      take_branch(next_rand() & 32'h1FF);
      consume_words(int'(next_rand() % 6), 100);
    end
    consume_words(4, 100);
    finish_test("branch");

    consume_words(40, 30);
    consume_words(40, 60);
    finish_test("backpressure");

    // Host reads while the fetch stream runs flat out
    take_branch(32'h100);
    fork
      consume_words(40, 100);
      begin
        for (int k = 0; k < 12; k++) begin
          check_ext_read((next_rand() % MEM_WORDS) * 4);
        end
      end
    join
    finish_test("sharing");

    fetch_req = 1'b0;
    repeat (4) @(negedge clk);
    total = total_errors();
    $display("Totals: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, total);
    if (total == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// ==== src/fetch_cfg_pkg.sv ====
// Fetch path constants and controller state encoding, imported by the prefetch controller
package fetch_cfg_pkg;

  ////////////////////////////////////////
  // Sizing and address constants
  ////////////////////////////////////////

  // First instruction address after reset
  parameter logic [31:0] BOOT_ADDR = 32'h0000_0040;

  // Every fetch is one full word
  parameter logic [31:0] WORD_BYTES = 32'd4;

  ////////////////////////////////////////
  // Controller states
  ////////////////////////////////////////

  // IDLE fetches sequentially from the last issued address
  // BRANCH_WAIT replays a target the arbiter has not accepted yet
  typedef enum logic {
    IDLE,
    BRANCH_WAIT
  } pf_state_e;

endpackage

// ==== src/fetch_fifo.sv ====
// Circular FIFO of fetched address/instruction pairs, head shown directly to the fetch stage
module fetch_fifo #(
  parameter int DEPTH = 4,
  localparam int CNT_W = $clog2(DEPTH + 1)
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             push_i,
  input  logic [31:0]      push_data_i,
  input  logic [31:0]      push_addr_i,
  input  logic             pop_i,
  input  logic             flush_i,
  output logic [31:0]      head_data_o,
  output logic [31:0]      head_addr_o,
  output logic [CNT_W-1:0] cnt_o,
  output logic             empty_o
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  logic [31:0]      data_mem [DEPTH];
  logic [31:0]      addr_mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] cnt_q;
  logic             do_push;
  logic             do_pop;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  // Guard against overflow and underflow
  assign do_push = push_i && (cnt_q < DEPTH);
  assign do_pop  = pop_i && (cnt_q != '0);

  assign head_data_o = data_mem[rd_ptr_q];
  assign head_addr_o = addr_mem[rd_ptr_q];
  assign cnt_o       = cnt_q;
  assign empty_o     = (cnt_q == '0);

  ////////////////////////////////////////
  // Pointers and occupancy
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else if (flush_i) begin
      // Flush beats a push in the same cycle
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (do_pop) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      case ({do_push, do_pop})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  // Entry storage
  always_ff @(posedge clk) begin
    if (do_push && !flush_i) begin
      data_mem[wr_ptr_q] <= push_data_i;
      addr_mem[wr_ptr_q] <= push_addr_i;
    end
  end

endmodule

// ==== src/instr_ram.sv ====
// Single-port instruction RAM answering each enabled access on the following cycle
module instr_ram
  import mem_bus_pkg::*;
#(
  parameter int MEM_WORDS = 256,
  localparam int IDX_W = $clog2(MEM_WORDS)
) (
  input  logic              clk,
  input  logic              en_i,
  input  logic              we_i,
  // Word index, byte offset already stripped
  input  logic [IDX_W-1:0]  addr_i,
  input  logic [DATA_W-1:0] wdata_i,
  output logic [DATA_W-1:0] rdata_o
);

  ////////////////////////////////////////
  // Storage
  ////////////////////////////////////////

  // Program contents come from the external port
  logic [DATA_W-1:0] mem_q [MEM_WORDS];

  // One cycle for reads and writes alike
  always_ff @(posedge clk) begin
    if (en_i) begin
      if (we_i) begin
        mem_q[addr_i] <= wdata_i;
        // Write-first, echo the stored word
        rdata_o       <= wdata_i;
      end else begin
        rdata_o <= mem_q[addr_i];
      end
    end
  end

endmodule

// ==== src/mem_arbiter.sv ====
// Round-robin arbiter sharing the instruction RAM between the fetch path and the external port
module mem_arbiter
  import mem_bus_pkg::*;
#(
  parameter int MEM_WORDS = 256,
  localparam int IDX_W = $clog2(MEM_WORDS)
) (
  input  logic              clk,
  input  logic              rst_n,
  // Fetch requester
  input  logic              trans_valid_i,
  input  logic [ADDR_W-1:0] trans_addr_i,
  output logic              trans_ready_o,
  output logic              resp_valid_o,
  output logic [DATA_W-1:0] resp_rdata_o,
  // External four-phase port
  input  logic              ext_req_i,
  input  mem_op_e           ext_op_i,
  input  logic [ADDR_W-1:0] ext_addr_i,
  input  logic [DATA_W-1:0] ext_wdata_i,
  output logic              ext_ack_o,
  output logic [DATA_W-1:0] ext_rdata_o,
  // RAM side
  output logic              mem_en_o,
  output logic              mem_we_o,
  output logic [IDX_W-1:0]  mem_addr_o,
  output logic [DATA_W-1:0] mem_wdata_o,
  input  logic [DATA_W-1:0] mem_rdata_i
);

  typedef enum logic [1:0] {
    EXT_WAIT,
    EXT_SERVED,
    EXT_ACK
  } ext_state_e;

  ext_state_e        ext_state_q;
  ext_state_e        ext_state_d;
  // Last winner loses the next tie
  mst_e              last_q;
  // Owner of the access answered this cycle
  mst_e              owner_q;
  logic              rsp_pend_q;
  logic              ext_pend;
  logic              gnt_fetch;
  logic              gnt_ext;
  logic [DATA_W-1:0] ext_rdata_q;

  ////////////////////////////////////////
  // Grant
  ////////////////////////////////////////

  // Only a fresh request counts, a held one was already served
  assign ext_pend      = ext_req_i && (ext_state_q == EXT_WAIT);
  assign trans_ready_o = !ext_pend || (last_q == MST_EXT);
  assign gnt_fetch     = trans_valid_i && trans_ready_o;
  assign gnt_ext       = ext_pend && (!trans_valid_i || (last_q == MST_FETCH));

  assign mem_en_o    = gnt_fetch || gnt_ext;
  assign mem_we_o    = gnt_ext && (ext_op_i == MEM_WRITE);
  assign mem_addr_o  = gnt_ext ? ext_addr_i[IDX_W+1:2] : trans_addr_i[IDX_W+1:2];
  assign mem_wdata_o = ext_wdata_i;

  ////////////////////////////////////////
  // Response routing
  ////////////////////////////////////////

  assign resp_valid_o = rsp_pend_q && (owner_q == MST_FETCH);
  assign resp_rdata_o = mem_rdata_i;
  assign ext_ack_o    = (ext_state_q == EXT_ACK);
  assign ext_rdata_o  = ext_rdata_q;

  // Four-phase sequencing of the external port
  always_comb begin
    ext_state_d = ext_state_q;
    case (ext_state_q)
      EXT_WAIT:   if (gnt_ext) ext_state_d = EXT_SERVED;
      EXT_SERVED: if (rsp_pend_q && (owner_q == MST_EXT)) ext_state_d = EXT_ACK;
      EXT_ACK:    if (!ext_req_i) ext_state_d = EXT_WAIT;
      default:    ext_state_d = EXT_WAIT;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ext_state_q <= EXT_WAIT;
      last_q      <= MST_EXT;
      owner_q     <= MST_FETCH;
      rsp_pend_q  <= 1'b0;
    end else begin
      ext_state_q <= ext_state_d;
      rsp_pend_q  <= mem_en_o;
      if (mem_en_o) begin
        last_q  <= gnt_ext ? MST_EXT : MST_FETCH;
        owner_q <= gnt_ext ? MST_EXT : MST_FETCH;
      end
    end
  end

  // Read data held for the host while ack is high
  always_ff @(posedge clk) begin
    if (rsp_pend_q && (owner_q == MST_EXT)) begin
      ext_rdata_q <= mem_rdata_i;
    end
  end

endmodule

// ==== src/mem_bus_pkg.sv ====
// Shared memory bus widths and encodings for the arbiter, the instruction RAM and the top level
package mem_bus_pkg;

  ////////////////////////////////////////
  // Bus widths
  ////////////////////////////////////////

  parameter int ADDR_W = 32;
  parameter int DATA_W = 32;

  ////////////////////////////////////////
  // Encodings
  ////////////////////////////////////////

  // Opcode of an external port access
  typedef enum logic {
    MEM_READ,
    MEM_WRITE
  } mem_op_e;

  // Owner of a granted RAM access
  // Registered by the arbiter to route the next-cycle response
  typedef enum logic {
    MST_FETCH,
    MST_EXT
  } mst_e;

endpackage

// ==== src/prefetch_ctrl.sv ====
// Prefetch controller that issues word fetches ahead of the fetch stage and steers the fetch FIFO
module prefetch_ctrl
  import fetch_cfg_pkg::*;
#(
  parameter int DEPTH = 4,
  localparam int CNT_W = $clog2(DEPTH + 1)
) (
  input  logic             clk,
  input  logic             rst_n,
  // Fetch stage side
  input  logic             fetch_req_i,
  input  logic             branch_i,
  input  logic [31:0]      branch_addr_i,
  input  logic             fetch_ready_i,
  output logic             busy_o,
  // Transaction request towards the arbiter
  output logic             trans_valid_o,
  output logic [31:0]      trans_addr_o,
  input  logic             trans_ready_i,
  input  logic             resp_valid_i,
  // FIFO control
  output logic             fifo_push_o,
  output logic             fifo_pop_o,
  output logic             fifo_flush_o,
  output logic [31:0]      fifo_push_addr_o,
  input  logic [CNT_W-1:0] fifo_cnt_i,
  input  logic             fifo_empty_i
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  pf_state_e        state_q;
  pf_state_e        state_d;
  // Fetch request seen one cycle earlier
  logic             req_q;
  // Last issued (or pending branch) address
  logic [31:0]      trans_addr_q;
  logic [31:0]      aligned_branch_addr;
  logic             accept;
  // FIFO words plus fetches in flight
  logic [CNT_W:0]   occ_sum;
  logic [CNT_W-1:0] cnt_q;
  logic [CNT_W-1:0] cnt_d;
  // Responses still to be dropped after a branch
  logic [CNT_W-1:0] flush_cnt_q;
  logic [CNT_W-1:0] flush_cnt_d;
  // Addresses of outstanding fetches, oldest at the read pointer
  logic [31:0]      aq_mem [DEPTH];
  logic [PTR_W-1:0] aq_wr_q;
  logic [PTR_W-1:0] aq_rd_q;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  ////////////////////////////////////////
  // Request generation
  ////////////////////////////////////////

  // Word fetches only
  assign aligned_branch_addr = {branch_addr_i[31:2], 2'b00};

  // Never let FIFO contents plus in-flight fetches pass DEPTH
  assign occ_sum       = fifo_cnt_i + cnt_q;
  assign trans_valid_o = req_q && (occ_sum < DEPTH);
  assign accept        = trans_valid_o && trans_ready_i;

  assign busy_o = (cnt_q != '0) || trans_valid_o;

  // Address select and branch replay
  always_comb begin
    state_d      = state_q;
    trans_addr_o = trans_addr_q;
    case (state_q)
      IDLE: begin
        trans_addr_o = branch_i ? aligned_branch_addr : trans_addr_q + WORD_BYTES;
        // Target not taken this cycle, hold it for replay
        if (branch_i && !accept) begin
          state_d = BRANCH_WAIT;
        end
      end
      BRANCH_WAIT: begin
        // A newer branch overrides the pending one
        trans_addr_o = branch_i ? aligned_branch_addr : trans_addr_q;
        if (accept) begin
          state_d = IDLE;
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  ////////////////////////////////////////
  // Outstanding and flush counters
  ////////////////////////////////////////

  always_comb begin
    case ({accept, resp_valid_i})
      2'b10:   cnt_d = cnt_q + 1'b1;
      2'b01:   cnt_d = cnt_q - 1'b1;
      default: cnt_d = cnt_q;
    endcase
  end

  // Old-path responses in flight at the branch get dropped
  // The one arriving in the branch cycle itself is dropped right away
  always_comb begin
    flush_cnt_d = flush_cnt_q;
    if (branch_i) begin
      flush_cnt_d = (resp_valid_i && (cnt_q != '0)) ? cnt_q - 1'b1 : cnt_q;
    end else if (resp_valid_i && (flush_cnt_q != '0)) begin
      flush_cnt_d = flush_cnt_q - 1'b1;
    end
  end

  ////////////////////////////////////////
  // FIFO control
  ////////////////////////////////////////

  assign fifo_push_o      = resp_valid_i && !branch_i && (flush_cnt_q == '0);
  assign fifo_pop_o       = !fifo_empty_i && fetch_ready_i;
  assign fifo_flush_o     = branch_i;
  // Responses come back in order, so the oldest queued address tags this one
  assign fifo_push_addr_o = aq_mem[aq_rd_q];

  ////////////////////////////////////////
  // Registers
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      // Boot address acts as a pending branch target
      state_q      <= BRANCH_WAIT;
      req_q        <= 1'b0;
      trans_addr_q <= BOOT_ADDR;
      cnt_q        <= '0;
      flush_cnt_q  <= '0;
      aq_wr_q      <= '0;
      aq_rd_q      <= '0;
    end else begin
      state_q     <= state_d;
      req_q       <= fetch_req_i;
      cnt_q       <= cnt_d;
      flush_cnt_q <= flush_cnt_d;
      if (branch_i || accept) begin
        trans_addr_q <= trans_addr_o;
      end
      if (accept) begin
        aq_wr_q <= ptr_inc(aq_wr_q);
      end
      // Dropped responses retire their address too
      if (resp_valid_i) begin
        aq_rd_q <= ptr_inc(aq_rd_q);
      end
    end
  end

  // Address queue storage
  always_ff @(posedge clk) begin
    if (accept) begin
      aq_mem[aq_wr_q] <= trans_addr_o;
    end
  end

endmodule

// ==== src/prefetch_top.sv ====
// Prefetch subsystem top level tying controller, FIFO, arbiter and RAM together
module prefetch_top
  import mem_bus_pkg::*;
#(
  parameter int DEPTH     = 4,
  parameter int MEM_WORDS = 256
) (
  input  logic              clk,
  input  logic              rst_n,
  // Fetch stage
  input  logic              fetch_req_i,
  input  logic              branch_i,
  input  logic [31:0]       branch_addr_i,
  input  logic              fetch_ready_i,
  output logic              fetch_valid_o,
  output logic [31:0]       fetch_instr_o,
  output logic [31:0]       fetch_addr_o,
  output logic              busy_o,
  // External load/store port
  input  logic              ext_req_i,
  input  mem_op_e           ext_op_i,
  input  logic [ADDR_W-1:0] ext_addr_i,
  input  logic [DATA_W-1:0] ext_wdata_i,
  output logic              ext_ack_o,
  output logic [DATA_W-1:0] ext_rdata_o
);

  localparam int CNT_W = $clog2(DEPTH + 1);
  localparam int IDX_W = $clog2(MEM_WORDS);

  // Controller to arbiter
  logic              trans_valid;
  logic [ADDR_W-1:0] trans_addr;
  logic              trans_ready;
  logic              resp_valid;
  logic [DATA_W-1:0] resp_rdata;
  // Controller to FIFO
  logic              fifo_push;
  logic              fifo_pop;
  logic              fifo_flush;
  logic [31:0]       fifo_push_addr;
  logic [CNT_W-1:0]  fifo_cnt;
  logic              fifo_empty;
  // Arbiter to RAM
  logic              mem_en;
  logic              mem_we;
  logic [IDX_W-1:0]  mem_addr;
  logic [DATA_W-1:0] mem_wdata;
  logic [DATA_W-1:0] mem_rdata;

  // Every word goes through the FIFO
  assign fetch_valid_o = !fifo_empty;

  prefetch_ctrl #(.DEPTH(DEPTH)) u_ctrl (
    .clk, .rst_n,
    .fetch_req_i, .branch_i, .branch_addr_i, .fetch_ready_i, .busy_o,
    .trans_valid_o    (trans_valid),
    .trans_addr_o     (trans_addr),
    .trans_ready_i    (trans_ready),
    .resp_valid_i     (resp_valid),
    .fifo_push_o      (fifo_push),
    .fifo_pop_o       (fifo_pop),
    .fifo_flush_o     (fifo_flush),
    .fifo_push_addr_o (fifo_push_addr),
    .fifo_cnt_i       (fifo_cnt),
    .fifo_empty_i     (fifo_empty)
  );

  fetch_fifo #(.DEPTH(DEPTH)) u_fifo (
    .clk, .rst_n,
    .push_i      (fifo_push),
    .push_data_i (resp_rdata),
    .push_addr_i (fifo_push_addr),
    .pop_i       (fifo_pop),
    .flush_i     (fifo_flush),
    .head_data_o (fetch_instr_o),
    .head_addr_o (fetch_addr_o),
    .cnt_o       (fifo_cnt),
    .empty_o     (fifo_empty)
  );

  mem_arbiter #(.MEM_WORDS(MEM_WORDS)) u_arb (
    .clk, .rst_n,
    .trans_valid_i (trans_valid),
    .trans_addr_i  (trans_addr),
    .trans_ready_o (trans_ready),
    .resp_valid_o  (resp_valid),
    .resp_rdata_o  (resp_rdata),
    .ext_req_i, .ext_op_i, .ext_addr_i, .ext_wdata_i, .ext_ack_o, .ext_rdata_o,
    .mem_en_o      (mem_en),
    .mem_we_o      (mem_we),
    .mem_addr_o    (mem_addr),
    .mem_wdata_o   (mem_wdata),
    .mem_rdata_i   (mem_rdata)
  );

  instr_ram #(.MEM_WORDS(MEM_WORDS)) u_ram (
    .clk,
    .en_i    (mem_en),
    .we_i    (mem_we),
    .addr_i  (mem_addr),
    .wdata_i (mem_wdata),
    .rdata_o (mem_rdata)
  );

endmodule

// ==== vlog.f ====
src/fetch_cfg_pkg.sv
src/mem_bus_pkg.sv
src/prefetch_ctrl.sv
src/fetch_fifo.sv
src/mem_arbiter.sv
src/instr_ram.sv
src/prefetch_top.sv
sim/prefetch_chk.sv
sim/tb_prefetch.sv
